//--- project.f
+incdir+src
src/core_pkg.sv
src/exec_control.sv
src/register_file.sv
src/execute_forwarding.sv
src/exec_alu.sv
src/exec_core_top.sv
testbench/exec_core_assertions.sv
testbench/exec_core_tb.sv

//--- src/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath width
`define CORE_DATA_W 32

// General registers, also the length of the clear sequence
`define CORE_GR_COUNT 32

// System register indices
`define SYSREG_SPR  5'd1
`define SYSREG_PDTR 5'd2
`define SYSREG_TIDR 5'd3
`define SYSREG_PSR  5'd4

// Stack pointer step for push
`define CORE_SP_STEP 4

`endif

//--- src/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

	// Data word
	typedef logic [`CORE_DATA_W-1:0] word_t;

	// General or system register pointer
	typedef logic [4:0] reg_idx_t;

	// Execute opcodes
	typedef enum logic [2:0] {
		op_mov   = 3'd0,
		op_add   = 3'd1,
		op_xor   = 3'd2,
		op_shl   = 3'd3,
		op_push  = 3'd4,
		op_setsp = 3'd5
	} opcode_t;

	// Control FSM
	typedef enum logic [1:0] {
		st_clear = 2'd0,
		st_run   = 2'd1,
		st_flush = 2'd2
	} ctrl_state_t;

endpackage

//--- src/exec_alu.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_alu (
	input  logic               clock,
	input  logic               arst_n,
	input  logic               issue,
	input  logic               flush,
	input  core_pkg::reg_idx_t instr_src,
	input  logic               instr_src_sys,
	input  logic               instr_src_imm,
	input  core_pkg::word_t    instr_imm,
	input  core_pkg::word_t    rd_data,
	input  core_pkg::word_t    rf_spr,
	input  core_pkg::word_t    rf_pdtr,
	input  core_pkg::word_t    rf_tidr,
	input  core_pkg::word_t    rf_psr,
	input  core_pkg::opcode_t  s_op,
	input  core_pkg::word_t    fwd_data,
	input  core_pkg::word_t    fwd_spr,
	output core_pkg::reg_idx_t s_src,
	output logic               s_src_sys,
	output logic               s_src_imm,
	output core_pkg::word_t    s_data,
	output core_pkg::word_t    s_spr,
	output core_pkg::word_t    s_pdtr,
	output core_pkg::word_t    s_tidr,
	output core_pkg::word_t    s_psr,
	output core_pkg::word_t    wb_data,
	output core_pkg::word_t    wb_spr_data,
	output core_pkg::word_t    pwb_data,
	output core_pkg::word_t    pwb_spr_data
);

	core_pkg::word_t s_imm;
	core_pkg::word_t op_a;
	core_pkg::word_t result;
	core_pkg::word_t spr_next;

	// Source selection, dropped on a pipeline flush
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			s_src     <= '0;
			s_src_sys <= 1'b0;
			s_src_imm <= 1'b0;
		end else if (flush) begin
			s_src     <= '0;
			s_src_sys <= 1'b0;
			s_src_imm <= 1'b0;
		end else if (issue) begin
			s_src     <= instr_src;
			s_src_sys <= instr_src_sys;
			s_src_imm <= instr_src_imm;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			s_data <= rd_data;
			s_imm  <= instr_imm;
		end
		// System registers sampled every cycle, keeps the live view current
		s_spr  <= rf_spr;
		s_pdtr <= rf_pdtr;
		s_tidr <= rf_tidr;
		s_psr  <= rf_psr;
	end

	assign op_a = s_src_imm ? s_imm : fwd_data;

	always_comb begin
		result   = op_a;
		spr_next = fwd_spr;
		case (s_op)
			core_pkg::op_mov:  result = op_a;
			core_pkg::op_add:  result = op_a + s_imm;
			core_pkg::op_xor:  result = op_a ^ s_imm;
			core_pkg::op_shl:  result = op_a << s_imm[4:0];
			core_pkg::op_push: spr_next = fwd_spr - core_pkg::word_t'(`CORE_SP_STEP);
			// dest also receives a
			core_pkg::op_setsp: spr_next = op_a;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		wb_data      <= result;
		wb_spr_data  <= spr_next;
		pwb_data     <= wb_data;
		pwb_spr_data <= wb_spr_data;
	end

endmodule

//--- src/exec_control.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_control (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  sync_clear,
	input  logic                  instr_valid,
	input  core_pkg::opcode_t     instr_op,
	input  core_pkg::reg_idx_t    instr_dest,
	input  logic                  instr_dest_sys,
	output logic                  ready,
	output logic                  issue,
	output logic                  s_valid,
	output logic                  wb_valid,
	output logic                  pwb_valid,
	output core_pkg::opcode_t     s_op,
	output core_pkg::reg_idx_t    wb_dest,
	output core_pkg::reg_idx_t    pwb_dest,
	output logic                  wb_dest_sys,
	output logic                  pwb_dest_sys,
	output logic                  wb_spr_wr,
	output logic                  pwb_spr_wr,
	output logic                  clear_en,
	output core_pkg::reg_idx_t    clear_idx
);

	core_pkg::ctrl_state_t state;
	core_pkg::ctrl_state_t state_next;
	core_pkg::reg_idx_t    s_dest;
	logic                  s_dest_sys;
	logic                  s_spr_wr;
	logic                  clear_last;

	assign ready      = (state == core_pkg::st_run);
	assign issue      = instr_valid && ready;
	assign clear_en   = (state == core_pkg::st_clear);
	assign clear_last = (clear_idx == core_pkg::reg_idx_t'(`CORE_GR_COUNT - 1));

	always_comb begin
		state_next = state;
		case (state)
			core_pkg::st_clear: begin
				if (clear_last)
					state_next = core_pkg::st_run;
			end
			core_pkg::st_run: begin
				if (sync_clear)
					state_next = core_pkg::st_flush;
			end
			core_pkg::st_flush: begin
				if (!sync_clear)
					state_next = core_pkg::st_run;
			end
			default: state_next = core_pkg::st_clear;
		endcase
	end

	// Clear index walks every register once, wraps back to zero
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state     <= core_pkg::st_clear;
			clear_idx <= '0;
		end else begin
			state <= state_next;
			if (clear_en)
				clear_idx <= clear_idx + 5'd1;
		end
	end

	// Valids and SPR-write kind, already qualified by valid
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			s_valid    <= 1'b0;
			wb_valid   <= 1'b0;
			pwb_valid  <= 1'b0;
			s_spr_wr   <= 1'b0;
			wb_spr_wr  <= 1'b0;
			pwb_spr_wr <= 1'b0;
		end else if (sync_clear) begin
			s_valid    <= 1'b0;
			wb_valid   <= 1'b0;
			pwb_valid  <= 1'b0;
			s_spr_wr   <= 1'b0;
			wb_spr_wr  <= 1'b0;
			pwb_spr_wr <= 1'b0;
		end else begin
			s_valid    <= issue;
			wb_valid   <= s_valid;
			pwb_valid  <= wb_valid;
			s_spr_wr   <= issue && (instr_op == core_pkg::op_push ||
				instr_op == core_pkg::op_setsp);
			wb_spr_wr  <= s_spr_wr;
			pwb_spr_wr <= wb_spr_wr;
		end
	end

	// Destination fields follow the valids
	always_ff @(posedge clock) begin
		if (issue) begin
			s_op       <= instr_op;
			s_dest     <= instr_dest;
			s_dest_sys <= instr_dest_sys;
		end
		wb_dest      <= s_dest;
		wb_dest_sys  <= s_dest_sys;
		pwb_dest     <= wb_dest;
		pwb_dest_sys <= wb_dest_sys;
	end

endmodule

//--- src/exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top (
	input  logic               clock,
	input  logic               arst_n,
	input  logic               sync_clear,
	input  logic               instr_valid,
	input  core_pkg::opcode_t  instr_op,
	input  core_pkg::reg_idx_t instr_dest,
	input  logic               instr_dest_sys,
	input  core_pkg::reg_idx_t instr_src,
	input  logic               instr_src_sys,
	input  logic               instr_src_imm,
	input  core_pkg::word_t    instr_imm,
	output logic               ready,
	output logic               commit_valid,
	output core_pkg::reg_idx_t commit_dest,
	output logic               commit_dest_sys,
	output core_pkg::word_t    commit_data,
	output logic               commit_spr_valid,
	output core_pkg::word_t    commit_spr,
	output core_pkg::word_t    spr,
	output core_pkg::word_t    pdtr,
	output core_pkg::word_t    tidr,
	output core_pkg::word_t    psr
);

	logic               issue, s_valid, wb_valid, wb_dest_sys, wb_spr_wr, clear_en;
	logic               s_src_sys, s_src_imm;
	core_pkg::opcode_t  s_op;
	core_pkg::reg_idx_t wb_dest, clear_idx, s_src;
	core_pkg::word_t    rd_data, rf_spr, rf_pdtr, rf_tidr, rf_psr;
	core_pkg::word_t    s_data, s_spr, s_pdtr, s_tidr, s_psr;
	core_pkg::word_t    wb_data, wb_spr_data, fwd_data;

	// Commit port is the pwb stage
	exec_control exec_control_i (
		.clock, .arst_n, .sync_clear, .instr_valid, .instr_op, .instr_dest,
		.instr_dest_sys, .ready, .issue, .s_valid, .wb_valid,
		.pwb_valid(commit_valid), .s_op, .wb_dest, .pwb_dest(commit_dest),
		.wb_dest_sys, .pwb_dest_sys(commit_dest_sys), .wb_spr_wr,
		.pwb_spr_wr(commit_spr_valid), .clear_en, .clear_idx
	);

	register_file register_file_i (
		.clock, .arst_n, .rd_idx(instr_src), .rd_sys(instr_src_sys),
		.wr_en(commit_valid), .wr_sys(commit_dest_sys), .wr_spr(commit_spr_valid),
		.wr_idx(commit_dest), .wr_data(commit_data), .wr_spr_data(commit_spr),
		.clear_en, .clear_idx, .rd_data, .spr(rf_spr), .pdtr(rf_pdtr),
		.tidr(rf_tidr), .psr(rf_psr)
	);

	// Live system outputs come from the forwarded view
	execute_forwarding execute_forwarding_i (
		.src_imm(s_src_imm), .src_sys(s_src_sys), .src_idx(s_src),
		.src_data(s_data), .src_spr(s_spr), .src_pdtr(s_pdtr),
		.src_tidr(s_tidr), .src_psr(s_psr),
		.wb_valid, .wb_dest_sys, .wb_spr_wr, .wb_dest, .wb_data, .wb_spr_data,
		.pwb_valid(commit_valid), .pwb_dest_sys(commit_dest_sys),
		.pwb_spr_wr(commit_spr_valid), .pwb_dest(commit_dest),
		.pwb_data(commit_data), .pwb_spr_data(commit_spr),
		.fwd_data, .fwd_spr(spr), .fwd_pdtr(pdtr), .fwd_tidr(tidr), .fwd_psr(psr)
	);

	exec_alu exec_alu_i (
		.clock, .arst_n, .issue, .flush(sync_clear), .instr_src, .instr_src_sys,
		.instr_src_imm, .instr_imm, .rd_data, .rf_spr, .rf_pdtr, .rf_tidr, .rf_psr,
		.s_op, .fwd_data, .fwd_spr(spr), .s_src, .s_src_sys, .s_src_imm, .s_data,
		.s_spr, .s_pdtr, .s_tidr, .s_psr, .wb_data, .wb_spr_data,
		.pwb_data(commit_data), .pwb_spr_data(commit_spr)
	);

endmodule

//--- src/execute_forwarding.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module execute_forwarding (
	input  logic               src_imm,
	input  logic               src_sys,
	input  core_pkg::reg_idx_t src_idx,
	input  core_pkg::word_t    src_data,
	input  core_pkg::word_t    src_spr,
	input  core_pkg::word_t    src_pdtr,
	input  core_pkg::word_t    src_tidr,
	input  core_pkg::word_t    src_psr,
	input  logic               wb_valid,
	input  logic               wb_dest_sys,
	input  logic               wb_spr_wr,
	input  core_pkg::reg_idx_t wb_dest,
	input  core_pkg::word_t    wb_data,
	input  core_pkg::word_t    wb_spr_data,
	input  logic               pwb_valid,
	input  logic               pwb_dest_sys,
	input  logic               pwb_spr_wr,
	input  core_pkg::reg_idx_t pwb_dest,
	input  core_pkg::word_t    pwb_data,
	input  core_pkg::word_t    pwb_spr_data,
	output core_pkg::word_t    fwd_data,
	output core_pkg::word_t    fwd_spr,
	output core_pkg::word_t    fwd_pdtr,
	output core_pkg::word_t    fwd_tidr,
	output core_pkg::word_t    fwd_psr
);

	// Operand patch from one writeback stage
	function automatic core_pkg::word_t patch_src(input core_pkg::word_t cur,
		input logic valid, input logic dest_sys, input logic spr_wr,
		input core_pkg::reg_idx_t dest, input core_pkg::word_t data,
		input core_pkg::word_t spr_data);
		logic src_is_spr;
		src_is_spr = src_sys && (src_idx == `SYSREG_SPR);
		if (!valid || src_imm)
			return cur;
		if (src_is_spr && spr_wr)
			return spr_data;
		// Same index and same register bank
		if (src_sys == dest_sys && src_idx == dest)
			return data;
		return cur;
	endfunction

	function automatic core_pkg::word_t patch_spr(input core_pkg::word_t cur,
		input logic valid, input logic dest_sys, input logic spr_wr,
		input core_pkg::reg_idx_t dest, input core_pkg::word_t data,
		input core_pkg::word_t spr_data);
		if (valid && spr_wr)
			return spr_data;
		if (valid && dest_sys && dest == `SYSREG_SPR)
			return data;
		return cur;
	endfunction

	function automatic core_pkg::word_t patch_sys(input core_pkg::reg_idx_t target,
		input core_pkg::word_t cur, input logic valid, input logic dest_sys,
		input core_pkg::reg_idx_t dest, input core_pkg::word_t data);
		if (valid && dest_sys && dest == target)
			return data;
		return cur;
	endfunction

	core_pkg::word_t prev_data, prev_spr, prev_pdtr, prev_tidr, prev_psr;

	// Older stage first and the newer wb result on top
	always_comb begin
		prev_data = patch_src(src_data, pwb_valid, pwb_dest_sys, pwb_spr_wr,
			pwb_dest, pwb_data, pwb_spr_data);
		fwd_data  = patch_src(prev_data, wb_valid, wb_dest_sys, wb_spr_wr,
			wb_dest, wb_data, wb_spr_data);
	end

	assign prev_spr = patch_spr(src_spr, pwb_valid, pwb_dest_sys, pwb_spr_wr,
		pwb_dest, pwb_data, pwb_spr_data);
	assign fwd_spr  = patch_spr(prev_spr, wb_valid, wb_dest_sys, wb_spr_wr,
		wb_dest, wb_data, wb_spr_data);

	assign prev_pdtr = patch_sys(`SYSREG_PDTR, src_pdtr, pwb_valid, pwb_dest_sys,
		pwb_dest, pwb_data);
	assign fwd_pdtr  = patch_sys(`SYSREG_PDTR, prev_pdtr, wb_valid, wb_dest_sys,
		wb_dest, wb_data);

	assign prev_tidr = patch_sys(`SYSREG_TIDR, src_tidr, pwb_valid, pwb_dest_sys,
		pwb_dest, pwb_data);
	assign fwd_tidr  = patch_sys(`SYSREG_TIDR, prev_tidr, wb_valid, wb_dest_sys,
		wb_dest, wb_data);

	assign prev_psr = patch_sys(`SYSREG_PSR, src_psr, pwb_valid, pwb_dest_sys,
		pwb_dest, pwb_data);
	assign fwd_psr  = patch_sys(`SYSREG_PSR, prev_psr, wb_valid, wb_dest_sys,
		wb_dest, wb_data);

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module register_file (
	input  logic               clock,
	input  logic               arst_n,
	input  core_pkg::reg_idx_t rd_idx,
	input  logic               rd_sys,
	input  logic               wr_en,
	input  logic               wr_sys,
	input  logic               wr_spr,
	input  core_pkg::reg_idx_t wr_idx,
	input  core_pkg::word_t    wr_data,
	input  core_pkg::word_t    wr_spr_data,
	input  logic               clear_en,
	input  core_pkg::reg_idx_t clear_idx,
	output core_pkg::word_t    rd_data,
	output core_pkg::word_t    spr,
	output core_pkg::word_t    pdtr,
	output core_pkg::word_t    tidr,
	output core_pkg::word_t    psr
);

	core_pkg::word_t gr [`CORE_GR_COUNT];
	core_pkg::word_t spr_q, pdtr_q, tidr_q, psr_q;

	// Next system register values, also the write-through read view
	always_comb begin
		spr  = spr_q;
		pdtr = pdtr_q;
		tidr = tidr_q;
		psr  = psr_q;
		if (wr_en && wr_sys) begin
			case (wr_idx)
				`SYSREG_SPR:  spr  = wr_data;
				`SYSREG_PDTR: pdtr = wr_data;
				`SYSREG_TIDR: tidr = wr_data;
				`SYSREG_PSR:  psr  = wr_data;
				default: ;
			endcase
		end
		// Push and setsp win over a system destination of SPR
		if (wr_spr)
			spr = wr_spr_data;
		if (clear_en) begin
			case (clear_idx)
				`SYSREG_SPR:  spr  = '0;
				`SYSREG_PDTR: pdtr = '0;
				`SYSREG_TIDR: tidr = '0;
				`SYSREG_PSR:  psr  = '0;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			spr_q  <= '0;
			pdtr_q <= '0;
			tidr_q <= '0;
			psr_q  <= '0;
		end else begin
			spr_q  <= spr;
			pdtr_q <= pdtr;
			tidr_q <= tidr;
			psr_q  <= psr;
		end
	end

	always_ff @(posedge clock) begin
		if (clear_en)
			gr[clear_idx] <= '0;
		else if (wr_en && !wr_sys)
			gr[wr_idx] <= wr_data;
	end

	always_comb begin
		if (rd_sys) begin
			case (rd_idx)
				`SYSREG_SPR:  rd_data = spr;
				`SYSREG_PDTR: rd_data = pdtr;
				`SYSREG_TIDR: rd_data = tidr;
				`SYSREG_PSR:  rd_data = psr;
				default:      rd_data = '0;
			endcase
		end else if (wr_en && !wr_sys && wr_idx == rd_idx) begin
			rd_data = wr_data;
		end else begin
			rd_data = gr[rd_idx];
		end
	end

endmodule

//--- testbench/exec_core_assertions.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_core_assertions (
	input logic               clock,
	input logic               arst_n,
	input logic               sync_clear,
	input logic               instr_valid,
	input core_pkg::opcode_t  instr_op,
	input core_pkg::reg_idx_t instr_dest,
	input logic               instr_dest_sys,
	input core_pkg::reg_idx_t instr_src,
	input logic               instr_src_sys,
	input logic               instr_src_imm,
	input core_pkg::word_t    instr_imm,
	input logic               ready,
	input logic               commit_valid,
	input core_pkg::reg_idx_t commit_dest,
	input logic               commit_dest_sys,
	input core_pkg::word_t    commit_data,
	input logic               commit_spr_valid,
	input core_pkg::word_t    commit_spr,
	input core_pkg::word_t    spr,
	input core_pkg::word_t    pdtr,
	input core_pkg::word_t    tidr,
	input core_pkg::word_t    psr
);

	int unsigned fail_count = 0;

	core_pkg::word_t gr_model [32];
	core_pkg::word_t sys_model [32];

	// Packed op, dest, dest_sys, src, src_sys, src_imm and imm
	logic [47:0]        fields_in;
	logic [47:0]        fields_q [3];
	logic [2:0]         valid_q;
	logic [5:0]         boot_cnt;
	logic               issue;
	core_pkg::opcode_t  c_op;
	core_pkg::reg_idx_t c_dest;
	logic               c_dest_sys;
	core_pkg::reg_idx_t c_src;
	logic               c_src_sys;
	logic               c_src_imm;
	core_pkg::word_t    c_imm;
	core_pkg::word_t    exp_a;
	core_pkg::word_t    exp_data;
	core_pkg::word_t    exp_spr;
	logic               exp_spr_wr;

	assign issue     = instr_valid && ready;
	assign fields_in = {instr_op, instr_dest, instr_dest_sys, instr_src, instr_src_sys,
		instr_src_imm, instr_imm};

	// Oldest entry is the instruction now at commit
	assign c_op       = core_pkg::opcode_t'(fields_q[2][47:45]);
	assign c_dest     = fields_q[2][44:40];
	assign c_dest_sys = fields_q[2][39];
	assign c_src      = fields_q[2][38:34];
	assign c_src_sys  = fields_q[2][33];
	assign c_src_imm  = fields_q[2][32];
	assign c_imm      = fields_q[2][31:0];

	always_comb begin
		if (c_src_imm)
			exp_a = c_imm;
		else if (c_src_sys)
			exp_a = sys_model[c_src];
		else
			exp_a = gr_model[c_src];
		exp_data   = exp_a;
		exp_spr    = sys_model[`SYSREG_SPR];
		exp_spr_wr = 1'b0;
		case (c_op)
			core_pkg::op_add: exp_data = exp_a + c_imm;
			core_pkg::op_xor: exp_data = exp_a ^ c_imm;
			core_pkg::op_shl: exp_data = exp_a << c_imm[4:0];
			core_pkg::op_push: begin
				exp_spr    = sys_model[`SYSREG_SPR] - `CORE_SP_STEP;
				exp_spr_wr = 1'b1;
			end
			core_pkg::op_setsp: begin
				exp_spr    = exp_a;
				exp_spr_wr = 1'b1;
			end
			default: ;
		endcase
	end

	// Shadow model takes each instruction when it reaches commit
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				gr_model[i]  <= '0;
				sys_model[i] <= '0;
			end
			valid_q  <= '0;
			boot_cnt <= '0;
		end else begin
			valid_q     <= sync_clear ? 3'b000 : {valid_q[1:0], issue};
			fields_q[0] <= fields_in;
			fields_q[1] <= fields_q[0];
			fields_q[2] <= fields_q[1];
			if (boot_cnt != 6'd63)
				boot_cnt <= boot_cnt + 6'd1;
			if (valid_q[2]) begin
				if (!c_dest_sys)
					gr_model[c_dest] <= exp_data;
				else if (c_dest >= `SYSREG_SPR && c_dest <= `SYSREG_PSR)
					sys_model[c_dest] <= exp_data;
				// SPR update lands last and wins
				if (exp_spr_wr)
					sys_model[`SYSREG_SPR] <= exp_spr;
			end
		end
	end

	// Low through the clear sequence, then low only in the cycle after sync_clear
	a_ready_level: assert property (@(posedge clock) disable iff (!arst_n)
		ready == (boot_cnt >= `CORE_GR_COUNT && !$past(sync_clear)))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: ready level wrong", $time);
		end

	a_commit_timing: assert property (@(posedge clock) disable iff (!arst_n)
		commit_valid == valid_q[2])
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: commit_valid is %0b, expected %0b", $time,
				commit_valid, valid_q[2]);
		end

	a_commit_data: assert property (@(posedge clock) disable iff (!arst_n)
		valid_q[2] |-> (commit_data == exp_data && commit_dest == c_dest &&
			commit_dest_sys == c_dest_sys))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: commit data %h, expected %h", $time,
				commit_data, exp_data);
		end

	a_commit_spr: assert property (@(posedge clock) disable iff (!arst_n)
		valid_q[2] |-> (commit_spr_valid == exp_spr_wr &&
			(!exp_spr_wr || commit_spr == exp_spr)))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: commit SPR %h, expected %h", $time,
				commit_spr, exp_spr);
		end

	a_flush_ready: assert property (@(posedge clock) disable iff (!arst_n)
		sync_clear |=> !ready && !commit_valid ##1 !commit_valid ##1 !commit_valid)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: flush left ready or a commit active", $time);
		end

	// Live view two samples back holds everything the model has now
	a_live_sysregs: assert property (@(posedge clock) disable iff (!arst_n)
		(boot_cnt > `CORE_GR_COUNT + 2 && !$past(sync_clear, 2)) |->
		{sys_model[1], sys_model[2], sys_model[3], sys_model[4]} ==
		$past({spr, pdtr, tidr, psr}, 2))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: live system registers differ from model", $time);
		end

endmodule

//--- testbench/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;

	logic               clock;
	logic               arst_n;
	logic               sync_clear;
	logic               instr_valid;
	core_pkg::opcode_t  instr_op;
	core_pkg::reg_idx_t instr_dest;
	logic               instr_dest_sys;
	core_pkg::reg_idx_t instr_src;
	logic               instr_src_sys;
	logic               instr_src_imm;
	core_pkg::word_t    instr_imm;
	logic               ready;
	logic               commit_valid;
	core_pkg::reg_idx_t commit_dest;
	logic               commit_dest_sys;
	core_pkg::word_t    commit_data;
	logic               commit_spr_valid;
	core_pkg::word_t    commit_spr;
	core_pkg::word_t    spr;
	core_pkg::word_t    pdtr;
	core_pkg::word_t    tidr;
	core_pkg::word_t    psr;

	logic [31:0] rng_state;
	int unsigned timeouts;
	int unsigned check_errors;
	int unsigned step;
	bit          ok;

	exec_core_top exec_core_top_i (.*);

	bind exec_core_top exec_core_assertions exec_core_assertions_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Small register set keeps forwarding busy
	task automatic drive_random_instr();
		logic [31:0] r;
		rng_state = xorshift32(rng_state);
		r = rng_state;
		rng_state = xorshift32(rng_state);
		instr_valid    = (r[31:28] != 4'd0);
		instr_op       = core_pkg::opcode_t'(r[2:0] % 3'd6);
		instr_dest_sys = (r[6:4] == 3'd0);
		instr_dest     = core_pkg::reg_idx_t'(r[8:7]) + (instr_dest_sys ? 5'd1 : 5'd0);
		instr_src_imm  = (r[11:9] == 3'd0);
		instr_src_sys  = (r[11:9] == 3'd1);
		instr_src      = core_pkg::reg_idx_t'(r[13:12]) + (instr_src_sys ? 5'd1 : 5'd0);
		instr_imm      = r[15] ? {24'd0, rng_state[7:0]} : rng_state;
	endtask

	task automatic wait_for_ready(output bit done);
		int unsigned cycles;
		cycles = 0;
		while (!ready && cycles < 100) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		done = ready;
		if (!done)
			$display("Timeout: ready did not rise within %0d cycles", cycles);
	endtask

	task automatic wait_for_drain(output bit done);
		int unsigned cycles;
		int unsigned quiet;
		cycles = 0;
		quiet  = 0;
		while (quiet < 5 && cycles < 50) begin
			@(posedge clock);
			#1;
			cycles++;
			quiet = commit_valid ? 0 : quiet + 1;
		end
		done = (quiet >= 5);
		if (!done)
			$display("Timeout: pipeline did not drain within %0d cycles", cycles);
	endtask

	// Flush with work in flight, plus one strobe that must be dropped
	task automatic pulse_flush(output bit done);
		drive_random_instr();
		sync_clear = 1'b1;
		@(posedge clock);
		#1;
		sync_clear  = 1'b0;
		instr_valid = 1'b0;
		wait_for_ready(done);
	endtask

	initial begin
		arst_n         = 1'b0;
		sync_clear     = 1'b0;
		instr_valid    = 1'b0;
		instr_op       = core_pkg::op_mov;
		instr_dest     = '0;
		instr_dest_sys = 1'b0;
		instr_src      = '0;
		instr_src_sys  = 1'b0;
		instr_src_imm  = 1'b0;
		instr_imm      = '0;
		rng_state      = 32'hb2035e89;
		timeouts       = 0;
		ok             = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		arst_n = 1'b1;
		wait_for_ready(ok);
		for (step = 0; step < 450 && ok; step++) begin
			@(posedge clock);
			#1;
			if (step % 150 == 149)
				pulse_flush(ok);
			else
				drive_random_instr();
		end
		if (ok) begin
			@(posedge clock);
			#1;
			instr_valid = 1'b0;
			wait_for_drain(ok);
		end
		if (!ok)
			timeouts++;
		check_errors = exec_core_top_i.exec_core_assertions_i.fail_count;
		$display("Summary: %0d check errors, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
